/* rtl/cpu_types_pkg.sv */
package cpu_types_pkg;

    // a data word or a byte address
    typedef logic [31:0] u32_t;

    // destination register index
    typedef logic [4:0] reg_idx_t;

endpackage

/* rtl/mem_access_pkg.sv */
package mem_access_pkg;

    typedef logic [1:0] access_size_t;  // width of a load or store
    typedef logic [1:0] byte_off_t;     // low address bits inside a word
    typedef logic [3:0] byte_mask_t;    // one enable per byte lane
    typedef logic [3:0] excp_code_t;

    localparam access_size_t SIZE_BYTE = 2'd0;
    localparam access_size_t SIZE_HALF = 2'd1;
    localparam access_size_t SIZE_WORD = 2'd2;

    localparam excp_code_t EXCP_NONE           = 4'd0;
    localparam excp_code_t EXCP_LOAD_MISALIGN  = 4'd4;
    localparam excp_code_t EXCP_STORE_MISALIGN = 4'd6;

    // cycles the data memory needs beyond the accepting edge
    localparam int DEFAULT_WAIT_STATES = 2;

endpackage

/* rtl/memory1_stage.sv */
`timescale 1ns/1ps

module memory1_stage
    import cpu_types_pkg::*, mem_access_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         stall,
    input  logic         flush,

    input  logic         in_bubble,
    input  u32_t         in_pc,
    input  u32_t         in_ex_out,
    input  u32_t         in_store_data,
    input  logic         in_is_load,
    input  logic         in_is_store,
    input  access_size_t in_size,
    input  logic         in_is_signed,
    input  logic         in_wr_rd,
    input  logic         in_wr_pc_plus4,
    input  reg_idx_t     in_rd,

    output logic         req_valid,
    output logic         req_write,
    output u32_t         req_addr,
    output u32_t         req_wdata,
    output byte_mask_t   req_mask,

    output logic         m1_bubble,
    output logic         m1_is_mem,
    output logic         m1_is_load,
    output logic         m1_is_signed,
    output logic         m1_wr_rd,
    output logic         m1_wr_pc_plus4,
    output access_size_t m1_size,
    output byte_off_t    m1_byte_off,
    output u32_t         m1_pc,
    output u32_t         m1_ex_out,
    output reg_idx_t     m1_rd,
    output excp_code_t   m1_excp_code
);

    u32_t store_data_r;
    logic is_store_r;
    logic misaligned;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            m1_bubble <= 1'b1;  // squashed slot becomes a bubble even under stall
        end else if (!stall) begin
            m1_bubble <= in_bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            m1_pc          <= in_pc;
            m1_ex_out      <= in_ex_out;
            store_data_r   <= in_store_data;
            m1_is_load     <= in_is_load;
            is_store_r     <= in_is_store;
            m1_size        <= in_size;
            m1_is_signed   <= in_is_signed;
            m1_wr_rd       <= in_wr_rd;
            m1_wr_pc_plus4 <= in_wr_pc_plus4;
            m1_rd          <= in_rd;
        end
    end

    assign m1_is_mem   = m1_is_load | is_store_r;
    assign m1_byte_off = m1_ex_out[1:0];

    always_comb begin
        unique case (m1_size)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = m1_byte_off[0];
            default:   misaligned = m1_byte_off != 2'b00;
        endcase
    end

    always_comb begin
        if (m1_is_mem && misaligned)
            m1_excp_code = m1_is_load ? EXCP_LOAD_MISALIGN : EXCP_STORE_MISALIGN;
        else
            m1_excp_code = EXCP_NONE;
    end

    // a flushed slot must not reach the memory on this edge
    assign req_valid = !m1_bubble && m1_is_mem && !misaligned && !flush;
    assign req_write = is_store_r;
    assign req_addr  = m1_ex_out;

    always_comb begin
        unique case (m1_size)
            SIZE_BYTE: begin
                req_wdata = {4{store_data_r[7:0]}};
                req_mask  = byte_mask_t'(4'b0001 << m1_byte_off);
            end
            SIZE_HALF: begin
                req_wdata = {2{store_data_r[15:0]}};
                req_mask  = byte_mask_t'(4'b0011 << m1_byte_off);
            end
            default: begin
                req_wdata = store_data_r;
                req_mask  = 4'b1111;
            end
        endcase
    end

endmodule

/* rtl/data_mem_ctrl.sv */
`timescale 1ns/1ps

module data_mem_ctrl
    import cpu_types_pkg::*, mem_access_pkg::*;
#(
    parameter int WAIT_STATES = DEFAULT_WAIT_STATES,
    parameter int MEM_WORDS   = 256
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,

    input  logic       req_valid,
    input  logic       req_write,
    input  u32_t       req_addr,
    input  u32_t       req_wdata,
    input  byte_mask_t req_mask,

    output u32_t       rdata,
    output logic       mem_ready
);

    localparam int AW    = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    typedef logic [AW-1:0] word_addr_t;

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_t;

    u32_t             ram [MEM_WORDS];
    word_addr_t       word_addr;
    state_t           state;
    logic [CNT_W-1:0] wait_cnt;
    logic             accept;

    // the request moves on with its instruction, so it is taken only when unstalled
    assign accept    = req_valid && !stall;
    assign word_addr = req_addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            wait_cnt <= '0;
        end else if (accept && WAIT_STATES != 0) begin
            state    <= ST_WAIT;
            wait_cnt <= CNT_W'(WAIT_STATES);
        end else if (state == ST_WAIT) begin
            if (wait_cnt == '0)
                state <= ST_IDLE;
            else
                wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign mem_ready = (state == ST_IDLE) || (wait_cnt == '0);

    always_ff @(posedge clk) begin
        if (accept) begin
            if (req_write) begin
                for (int i = 0; i < 4; i++) begin
                    if (req_mask[i])
                        ram[word_addr][8*i +: 8] <= req_wdata[8*i +: 8];
                end
            end else begin
                rdata <= ram[word_addr];  // held until the next accepted access
            end
        end
    end

endmodule

/* rtl/memory2_stage.sv */
`timescale 1ns/1ps

module memory2_stage
    import cpu_types_pkg::*, mem_access_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         stall,
    input  logic         flush,

    input  logic         m1_bubble,
    input  logic         m1_is_mem,
    input  logic         m1_is_load,
    input  logic         m1_is_signed,
    input  logic         m1_wr_rd,
    input  logic         m1_wr_pc_plus4,
    input  access_size_t m1_size,
    input  byte_off_t    m1_byte_off,
    input  u32_t         m1_pc,
    input  u32_t         m1_ex_out,
    input  reg_idx_t     m1_rd,
    input  excp_code_t   m1_excp_code,

    input  u32_t         rdata,
    input  logic         mem_ready,

    output logic         dcache_stall,

    output logic         fwd_valid,
    output reg_idx_t     fwd_idx,
    output u32_t         fwd_data,

    output logic         wb_valid,
    output logic         wb_we,
    output u32_t         wb_pc,
    output u32_t         wb_data,
    output reg_idx_t     wb_rd,
    output excp_code_t   wb_excp_code
);

    logic         bubble_r;
    logic         is_mem_r;
    logic         is_load_r;
    logic         is_signed_r;
    logic         wr_rd_r;
    logic         wr_pc_plus4_r;
    access_size_t size_r;
    byte_off_t    byte_off_r;
    u32_t         ex_out_r;
    logic [7:0]   mem_byte;
    logic [15:0]  mem_half;
    u32_t         mem_out;
    u32_t         result;
    logic         no_excp;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            bubble_r <= 1'b1;
        end else if (!stall) begin
            bubble_r <= m1_bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            is_mem_r      <= m1_is_mem;
            is_load_r     <= m1_is_load;
            is_signed_r   <= m1_is_signed;
            wr_rd_r       <= m1_wr_rd;
            wr_pc_plus4_r <= m1_wr_pc_plus4;
            size_r        <= m1_size;
            byte_off_r    <= m1_byte_off;
            ex_out_r      <= m1_ex_out;
            wb_pc         <= m1_pc;
            wb_rd         <= m1_rd;
            wb_excp_code  <= m1_excp_code;
        end
    end

    assign no_excp = wb_excp_code == EXCP_NONE;

    assign mem_byte = rdata[8*byte_off_r +: 8];
    assign mem_half = byte_off_r[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        unique case (size_r)
            SIZE_BYTE: mem_out = is_signed_r ? {{24{mem_byte[7]}}, mem_byte} : {24'b0, mem_byte};
            SIZE_HALF: mem_out = is_signed_r ? {{16{mem_half[15]}}, mem_half} : {16'b0, mem_half};
            default:   mem_out = rdata;
        endcase
    end

    always_comb begin
        if (wr_pc_plus4_r)
            result = wb_pc + 32'd4;
        else if (is_load_r)
            result = mem_out;
        else
            result = ex_out_r;
    end

    // a misaligned access never reached the memory, so it has nothing to wait for
    assign dcache_stall = !bubble_r && is_mem_r && no_excp && !mem_ready;

    // load data is only forwarded once the memory has returned it
    assign fwd_valid = !bubble_r && wr_rd_r && no_excp && (!is_load_r || mem_ready);
    assign fwd_idx   = wb_rd;
    assign fwd_data  = result;

    assign wb_valid = !bubble_r && !stall && !flush;
    assign wb_we    = wr_rd_r && no_excp;
    assign wb_data  = result;

endmodule

/* rtl/mem_pipe_top.sv */
`timescale 1ns/1ps

module mem_pipe_top
    import cpu_types_pkg::*, mem_access_pkg::*;
#(
    parameter int WAIT_STATES = DEFAULT_WAIT_STATES,
    parameter int MEM_WORDS   = 256
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush,

    input  logic         in_bubble,
    input  u32_t         in_pc,
    input  u32_t         in_ex_out,
    input  u32_t         in_store_data,
    input  logic         in_is_load,
    input  logic         in_is_store,
    input  access_size_t in_size,
    input  logic         in_is_signed,
    input  logic         in_wr_rd,
    input  logic         in_wr_pc_plus4,
    input  reg_idx_t     in_rd,
    output logic         in_ready,

    output logic         fwd_valid,
    output reg_idx_t     fwd_idx,
    output u32_t         fwd_data,

    output logic         wb_valid,
    output logic         wb_we,
    output u32_t         wb_pc,
    output u32_t         wb_data,
    output reg_idx_t     wb_rd,
    output excp_code_t   wb_excp_code
);

    logic         stall;
    logic         dcache_stall;
    logic         req_valid;
    logic         req_write;
    u32_t         req_addr;
    u32_t         req_wdata;
    byte_mask_t   req_mask;
    u32_t         rdata;
    logic         mem_ready;
    logic         m1_bubble;
    logic         m1_is_mem;
    logic         m1_is_load;
    logic         m1_is_signed;
    logic         m1_wr_rd;
    logic         m1_wr_pc_plus4;
    access_size_t m1_size;
    byte_off_t    m1_byte_off;
    u32_t         m1_pc;
    u32_t         m1_ex_out;
    reg_idx_t     m1_rd;
    excp_code_t   m1_excp_code;

    assign stall    = dcache_stall;  // the data memory is the only stall source here
    assign in_ready = !stall;

    memory1_stage memory1_i (
        .clk, .rst_n, .stall, .flush,
        .in_bubble, .in_pc, .in_ex_out, .in_store_data,
        .in_is_load, .in_is_store, .in_size, .in_is_signed,
        .in_wr_rd, .in_wr_pc_plus4, .in_rd,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_mask,
        .m1_bubble, .m1_is_mem, .m1_is_load, .m1_is_signed,
        .m1_wr_rd, .m1_wr_pc_plus4, .m1_size, .m1_byte_off,
        .m1_pc, .m1_ex_out, .m1_rd, .m1_excp_code
    );

    data_mem_ctrl #(
        .WAIT_STATES(WAIT_STATES),
        .MEM_WORDS  (MEM_WORDS)
    ) data_mem_i (
        .clk, .rst_n, .stall,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_mask,
        .rdata, .mem_ready
    );

    memory2_stage memory2_i (
        .clk, .rst_n, .stall, .flush,
        .m1_bubble, .m1_is_mem, .m1_is_load, .m1_is_signed,
        .m1_wr_rd, .m1_wr_pc_plus4, .m1_size, .m1_byte_off,
        .m1_pc, .m1_ex_out, .m1_rd, .m1_excp_code,
        .rdata, .mem_ready,
        .dcache_stall,
        .fwd_valid, .fwd_idx, .fwd_data,
        .wb_valid, .wb_we, .wb_pc, .wb_data, .wb_rd, .wb_excp_code
    );

endmodule

/* test/mem_pipe_assertions.sv */
`timescale 1ns/1ps

module mem_pipe_assertions
    import cpu_types_pkg::*, mem_access_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       stall,
    input logic       flush,
    input logic       m1_bubble,
    input logic       m1_is_mem,
    input logic       dcache_stall,
    input logic       wb_valid,
    input logic       wb_we,
    input u32_t       wb_pc,
    input u32_t       wb_data,
    input reg_idx_t   wb_rd,
    input excp_code_t wb_excp_code
);

    // a stall only starts when a real memory operation has just moved into memory2
    a_no_stall_for_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dcache_stall) |-> $past(!m1_bubble && m1_is_mem && !stall && !flush))
        else $error("dcache_stall raised while memory2 holds a bubble");

    a_no_wb_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_stall |-> !wb_valid)
        else $error("wb_valid high during a stall");

    // the stage registers are frozen, so the whole writeback bundle holds
    a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(wb_pc) && $stable(wb_data) && $stable(wb_rd)
                  && $stable(wb_we) && $stable(wb_excp_code))
        else $error("writeback fields changed while stalled");

endmodule

/* test/mem_pipe_tb.sv */
`timescale 1ns/1ps

module mem_pipe_tb
    import cpu_types_pkg::*, mem_access_pkg::*;
();

    localparam int TIMEOUT = 40;

    typedef struct {
        u32_t       pc;
        reg_idx_t   rd;
        u32_t       data;
        logic       we;
        logic       ld;
        excp_code_t excp;
    } expect_t;

    logic         clk;
    logic         rst_n;
    logic         flush;
    logic         in_bubble;
    u32_t         in_pc;
    u32_t         in_ex_out;
    u32_t         in_store_data;
    logic         in_is_load;
    logic         in_is_store;
    access_size_t in_size;
    logic         in_is_signed;
    logic         in_wr_rd;
    logic         in_wr_pc_plus4;
    reg_idx_t     in_rd;
    logic         in_ready;
    logic         fwd_valid;
    reg_idx_t     fwd_idx;
    u32_t         fwd_data;
    logic         wb_valid;
    logic         wb_we;
    u32_t         wb_pc;
    u32_t         wb_data;
    reg_idx_t     wb_rd;
    excp_code_t   wb_excp_code;

    u32_t    shadow [256];  // indexed by byte address bits 9:2 like the RAM
    expect_t exp_q [$];     // issued and not yet written back, oldest first
    u32_t    seed = 32'd60050;
    u32_t    next_pc = 32'h1000;
    u32_t    addrs [8];
    int      errors = 0;
    int      errors_at_start = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    logic    hung = 1'b0;

    mem_pipe_top #(.WAIT_STATES(2), .MEM_WORDS(256)) dut_i (.*);

    bind memory2_stage mem_pipe_assertions assertions_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic u32_t lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // expected writeback of one instruction, applied to the shadow memory in issue order
    function automatic void ref_model(input logic ld, st, input access_size_t size,
                                      input logic sgn, wr, pc4, input u32_t pc, addr, sdata,
                                      output expect_t e);
        u32_t       word;
        logic [1:0] off;
        logic       misalign;
        off      = addr[1:0];
        word     = shadow[addr[9:2]];
        misalign = (size == SIZE_HALF) ? off[0] : (size == SIZE_WORD) && (off != 2'd0);
        e.pc     = pc;
        e.ld     = ld;
        e.excp   = EXCP_NONE;
        if ((ld || st) && misalign)
            e.excp = ld ? EXCP_LOAD_MISALIGN : EXCP_STORE_MISALIGN;
        e.we = wr && (e.excp == EXCP_NONE);
        if (st && !misalign) begin
            case (size)
                SIZE_BYTE: word[8*off +: 8] = sdata[7:0];
                SIZE_HALF: word[8*off +: 16] = sdata[15:0];
                default:   word = sdata;
            endcase
            shadow[addr[9:2]] = word;
        end
        if (pc4)
            e.data = pc + 32'd4;
        else if (!ld)
            e.data = addr;  // stores and alu ops carry the execute result
        else if (size == SIZE_BYTE)
            e.data = sgn ? u32_t'($signed(word[8*off +: 8])) : u32_t'(word[8*off +: 8]);
        else if (size == SIZE_HALF)
            e.data = sgn ? u32_t'($signed(word[16*off[1] +: 16])) : u32_t'(word[16*off[1] +: 16]);
        else
            e.data = word;
    endfunction

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!in_ready && !hung) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: in_ready stayed low for %0d cycles", TIMEOUT);
                errors++;
                hung = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        in_bubble = 1'b1;  // the last instruction was taken at the edge just passed
        while (exp_q.size() != 0 && !hung) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: %0d writebacks never arrived", exp_q.size());
                errors++;
                hung = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic issue(input logic ld, st, input access_size_t size, input logic sgn, wr, pc4,
                         input reg_idx_t rd, input u32_t addr, sdata, input bit record);
        expect_t e;
        wait_ready();
        if (!hung) begin
            in_bubble      = 1'b0;
            in_pc          = next_pc;
            in_ex_out      = addr;
            in_store_data  = sdata;
            in_is_load     = ld;
            in_is_store    = st;
            in_size        = size;
            in_is_signed   = sgn;
            in_wr_rd       = wr;
            in_wr_pc_plus4 = pc4;
            in_rd          = rd;
            if (record) begin
                ref_model(ld, st, size, sgn, wr, pc4, next_pc, addr, sdata, e);
                e.rd = rd;
                exp_q.push_back(e);
            end
            next_pc += 32'd4;
        end
    endtask

    task automatic store(input access_size_t size, input u32_t addr, data);
        issue(1'b0, 1'b1, size, 1'b0, 1'b0, 1'b0, 5'd0, addr, data, 1'b1);
    endtask

    task automatic load(input access_size_t size, input logic sgn, input u32_t addr,
                        input reg_idx_t rd);
        issue(1'b1, 1'b0, size, sgn, 1'b1, 1'b0, rd, addr, 32'd0, 1'b1);
    endtask

    task automatic alu(input reg_idx_t rd, input u32_t value, input logic pc4);
        issue(1'b0, 1'b0, SIZE_WORD, 1'b0, 1'b1, pc4, rd, value, 32'd0, 1'b1);
    endtask

    task automatic end_test(input string name);
        drain();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %-10s ok", name);
        end else begin
            tests_failed++;
            $display("test %-10s %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    always @(posedge clk) begin : compare
        expect_t e;
        // a forwarding memory2 instruction is always the oldest one outstanding
        if (rst_n === 1'b1 && fwd_valid && exp_q.size() != 0) begin
            if (!in_ready && exp_q[0].ld) begin
                $display("load in memory2 forwarded before its data was ready");
                errors++;
            end
            if (fwd_idx !== exp_q[0].rd) begin
                $display("FAIL fwd_idx got %h expected %h", fwd_idx, exp_q[0].rd);
                errors++;
            end
            if (fwd_data !== exp_q[0].data) begin
                $display("FAIL fwd_data got %h expected %h", fwd_data, exp_q[0].data);
                errors++;
            end
        end
        if (rst_n === 1'b1 && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("writeback from pc %h with no instruction outstanding", wb_pc);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (wb_pc !== e.pc) begin
                    $display("FAIL wb_pc got %h expected %h", wb_pc, e.pc);
                    errors++;
                end
                if (wb_rd !== e.rd) begin
                    $display("FAIL wb_rd got %h expected %h", wb_rd, e.rd);
                    errors++;
                end
                if (wb_we !== e.we) begin
                    $display("FAIL wb_we got %h expected %h", wb_we, e.we);
                    errors++;
                end
                if (wb_excp_code !== e.excp) begin
                    $display("FAIL wb_excp_code got %h expected %h", wb_excp_code, e.excp);
                    errors++;
                end
                if (e.excp == EXCP_NONE && wb_data !== e.data) begin
                    $display("FAIL wb_data got %h expected %h", wb_data, e.data);
                    errors++;
                end
            end
        end
    end

    initial begin
        u32_t r;
        rst_n          = 1'b0;
        flush          = 1'b0;
        in_bubble      = 1'b1;
        in_pc          = '0;
        in_ex_out      = '0;
        in_store_data  = '0;
        in_is_load     = 1'b0;
        in_is_store    = 1'b0;
        in_size        = SIZE_WORD;
        in_is_signed   = 1'b0;
        in_wr_rd       = 1'b0;
        in_wr_pc_plus4 = 1'b0;
        in_rd          = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 8; i++) begin
            addrs[i] = (lcg() >> 12) & 32'h3fc;
            store(SIZE_WORD, addrs[i], lcg());
        end
        for (int i = 0; i < 8; i++)
            load(SIZE_WORD, 1'b0, addrs[i], reg_idx_t'(i + 1));
        end_test("word");

        for (int k = 0; k < 2; k++) begin
            store(SIZE_WORD, 32'h100, (k == 0) ? 32'h7f80_01ff : 32'h80ff_7e01);
            for (int off = 0; off < 4; off++) begin
                load(SIZE_BYTE, 1'b1, 32'h100 + off, 5'd3);
                load(SIZE_BYTE, 1'b0, 32'h100 + off, 5'd4);
                if (off % 2 == 0) begin
                    load(SIZE_HALF, 1'b1, 32'h100 + off, 5'd5);
                    load(SIZE_HALF, 1'b0, 32'h100 + off, 5'd6);
                end
            end
            store(SIZE_BYTE, 32'h101, lcg());  // upper data bits must be ignored
            store(SIZE_HALF, 32'h102, lcg());
            load(SIZE_WORD, 1'b0, 32'h100, 5'd7);
        end
        end_test("subword");

        for (int i = 0; i < 16; i++) begin
            r = lcg();
            case (r[31:30])
                2'd0:    alu(r[4:0], lcg(), 1'b0);
                2'd1:    alu(r[4:0], lcg(), 1'b1);
                2'd2:    load(SIZE_WORD, 1'b0, addrs[r[10:8]], r[4:0]);
                default: store(SIZE_WORD, addrs[r[10:8]], lcg());
            endcase
        end
        end_test("mixed");

        store(SIZE_WORD, 32'h200, lcg());
        store(SIZE_HALF, 32'h201, lcg());
        store(SIZE_WORD, 32'h202, lcg());
        store(SIZE_HALF, 32'h203, lcg());
        load(SIZE_HALF, 1'b1, 32'h203, 5'd8);
        load(SIZE_WORD, 1'b0, 32'h201, 5'd9);
        load(SIZE_WORD, 1'b0, 32'h200, 5'd10);
        end_test("misaligned");

        for (int i = 0; i < 6; i++) begin
            load(SIZE_WORD, 1'b0, addrs[i], 5'd11);
            alu(5'd11, lcg(), i % 2 == 1);
        end
        end_test("forward");

        store(SIZE_WORD, 32'h300, lcg());
        drain();
        issue(1'b0, 1'b0, SIZE_WORD, 1'b0, 1'b1, 1'b0, 5'd12, lcg(), 32'd0, 1'b0);
        issue(1'b0, 1'b1, SIZE_WORD, 1'b0, 1'b0, 1'b0, 5'd0, 32'h300, lcg(), 1'b0);
        @(negedge clk);
        flush     = 1'b1;  // alu op sits in memory2 and the store in memory1
        in_bubble = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        load(SIZE_WORD, 1'b0, 32'h300, 5'd13);
        end_test("flush");

        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* mem_pipe.f */
rtl/cpu_types_pkg.sv
rtl/mem_access_pkg.sv
rtl/memory1_stage.sv
rtl/data_mem_ctrl.sv
rtl/memory2_stage.sv
rtl/mem_pipe_top.sv
test/mem_pipe_assertions.sv
test/mem_pipe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_pipe_tb
FILELIST  ?= mem_pipe.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
